// ==== hdl/ntt_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ntt package
// ring constants, widths and the forward twiddle table for the
// 16-point NTT over q = 97, w = 8
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package ntt_pkg;

    // ring geometry
    localparam int RING_DEPTH = 4;                 // log2 of ring size
    localparam int RING_SIZE  = 1 << RING_DEPTH;   // 16 coefficients

    // word widths
    localparam int DATA_W = 7;                     // q < 128
    localparam int ADDR_W = RING_DEPTH;

    localparam int Q_MOD        = 97;
    localparam int BFLY_LATENCY = 3;               // mult, reduce, add/sub

    typedef logic [DATA_W-1:0] coef_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // w^k mod q for k = 0..7, w = 8 is a primitive 16th root (8^8 = -1)
    localparam coef_t TWIDDLE [RING_SIZE/2] = '{
        7'd1,
        7'd8,
        7'd64,
        7'd27,
        7'd22,
        7'd79,
        7'd50,
        7'd12
    };

endpackage

`default_nettype wire

// ==== hdl/coef_mem_if.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// coefficient memory interface
// two comb read ports and a paired write port for the butterfly
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

interface coef_mem_if;

    ntt_pkg::addr_t rd_addr_a;    // butterfly top input, also output readout
    ntt_pkg::addr_t rd_addr_b;    // butterfly bottom input
    ntt_pkg::coef_t rd_data_a;    // valid same cycle as address
    ntt_pkg::coef_t rd_data_b;

    logic           wr_en;        // writes both a and b on the edge
    ntt_pkg::addr_t wr_addr_a;
    ntt_pkg::addr_t wr_addr_b;
    ntt_pkg::coef_t wr_data_a;
    ntt_pkg::coef_t wr_data_b;

    modport ctrl (output rd_addr_a, rd_addr_b, wr_en, wr_addr_a, wr_addr_b,
                  wr_data_a, wr_data_b, input rd_data_a, rd_data_b);

    modport mem (input rd_addr_a, rd_addr_b, wr_en, wr_addr_a, wr_addr_b,
                 wr_data_a, wr_data_b, output rd_data_a, rd_data_b);

endinterface

`default_nettype wire

// ==== hdl/mod_butterfly.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// modular butterfly
// 3-stage CT butterfly mod q: a + b*w, a - b*w
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module mod_butterfly (
    input  wire                 clk,
    input  wire                 reset,
    input  wire ntt_pkg::coef_t in_a,
    input  wire ntt_pkg::coef_t in_b,
    input  wire ntt_pkg::coef_t tw,
    output ntt_pkg::coef_t      out_a,
    output ntt_pkg::coef_t      out_b
);

    localparam int W = ntt_pkg::DATA_W;

    logic [2*W-1:0] prod;         // stage 1, b*w < 97*96
    ntt_pkg::coef_t a_d1, a_d2;   // a travelling alongside
    ntt_pkg::coef_t t;            // stage 2, b*w mod q

    logic [W:0] sum, dif;         // one extra bit for carry / borrow

    always_comb begin
        sum = {1'b0, a_d2} + {1'b0, t};
        dif = {1'b0, a_d2} - {1'b0, t};   // msb set when a < t
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            prod  <= '0;
            a_d1  <= '0;
            a_d2  <= '0;
            t     <= '0;
            out_a <= '0;
            out_b <= '0;
        end else begin
            // stage 1, full width product
            prod <= {{W{1'b0}}, in_b} * {{W{1'b0}}, tw};
            a_d1 <= in_a;
            // stage 2, reduction by constant q
            t    <= ntt_pkg::coef_t'(prod % (2*W)'(ntt_pkg::Q_MOD));
            a_d2 <= a_d1;
            // stage 3, single correction each side
            out_a <= (sum >= (W+1)'(ntt_pkg::Q_MOD))
                         ? ntt_pkg::coef_t'(sum - (W+1)'(ntt_pkg::Q_MOD))
                         : sum[W-1:0];
            out_b <= dif[W] ? ntt_pkg::coef_t'(dif + (W+1)'(ntt_pkg::Q_MOD))   // wrap back into range
                            : dif[W-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/ntt_loader.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ntt loader
// samples 16 serial words, writes them bit-reversed
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module ntt_loader (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 load_data,
    input  wire ntt_pkg::coef_t din,
    output logic                ld_en,
    output ntt_pkg::addr_t      ld_addr,
    output ntt_pkg::coef_t      ld_data
);

    logic           busy;
    ntt_pkg::addr_t cnt;       // index j of the word on din
    ntt_pkg::addr_t cnt_rev;   // bitrev(j)

    always_comb begin
        for (int i = 0; i < ntt_pkg::ADDR_W; i++)
            cnt_rev[i] = cnt[ntt_pkg::ADDR_W-1-i];
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy  <= 1'b0;
            cnt   <= '0;
            ld_en <= 1'b0;
        end else begin
            ld_en <= busy;                     // one write per sampled word
            if (!busy) begin
                busy <= load_data;             // pulse while loading is ignored
                cnt  <= '0;
            end else begin
                cnt <= cnt + 1'b1;
                if (cnt == ntt_pkg::addr_t'(ntt_pkg::RING_SIZE - 1))
                    busy <= 1'b0;              // 16th word taken
            end
        end
    end

    // sampled word and its scrambled address, written next cycle
    always_ff @(posedge clk) begin
        ld_data <= din;
        ld_addr <= cnt_rev;
    end

endmodule

`default_nettype wire

// ==== hdl/coef_buffer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// coefficient buffer
// 16-word register file, loader port plus butterfly pair
// write and two comb reads
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module coef_buffer (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 ld_en,
    input  wire ntt_pkg::addr_t ld_addr,
    input  wire ntt_pkg::coef_t ld_data,
    coef_mem_if.mem             mem
);

    ntt_pkg::coef_t regs [ntt_pkg::RING_SIZE];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < ntt_pkg::RING_SIZE; i++)
                regs[i] <= '0;
        end else if (ld_en) begin
            regs[ld_addr] <= ld_data;           // serial load, bit-reversed slot
        end else if (mem.wr_en) begin
            // a and b never collide within a butterfly
            regs[mem.wr_addr_a] <= mem.wr_data_a;
            regs[mem.wr_addr_b] <= mem.wr_data_b;
        end
    end

    // async reads, data same cycle
    assign mem.rd_data_a = regs[mem.rd_addr_a];
    assign mem.rd_data_b = regs[mem.rd_addr_b];

endmodule

`default_nettype wire

// ==== hdl/ntt_ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ntt controller
// DIT stage/butterfly sequencing, twiddle lookup, write-back
// pipe, done pulse and natural order readout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module ntt_ctrl (
    input  wire            clk,
    input  wire            reset,
    input  wire            start,
    coef_mem_if.ctrl       mem,
    output logic           done,
    output ntt_pkg::coef_t dout,
    output logic           dout_valid
);

    localparam int L = ntt_pkg::BFLY_LATENCY;

    enum logic [1:0] {IDLE, COMPUTE, DRAIN, OUTPUT} state;

    logic [1:0]     s;      // stage
    logic [2:0]     j;      // butterfly within stage
    ntt_pkg::addr_t cnt;    // drain wait, then output index

    ntt_pkg::addr_t half, grp, pos, addr_a, addr_b;
    logic [2:0]     tw_idx;
    ntt_pkg::coef_t tw;

    // write-back address pipe, matches butterfly latency
    ntt_pkg::addr_t  a_pipe [L];
    ntt_pkg::addr_t  b_pipe [L];
    logic [L-1:0]    v_pipe;

    always_comb begin
        half   = ntt_pkg::addr_t'(1) << s;        // 2^s
        grp    = ntt_pkg::addr_t'(j) >> s;
        pos    = ntt_pkg::addr_t'(j) & (half - 1'b1);
        addr_a = ((grp << s) << 1) | pos;         // grp * 2^(s+1) + pos
        addr_b = addr_a + half;
        tw_idx = pos[2:0] << (2'd3 - s);          // pos * 2^(3-s)
    end

    assign tw = ntt_pkg::TWIDDLE[tw_idx];

    assign mem.rd_addr_a = (state == OUTPUT) ? cnt : addr_a;   // port a reused for readout
    assign mem.rd_addr_b = addr_b;
    assign mem.wr_en     = v_pipe[L-1];
    assign mem.wr_addr_a = a_pipe[L-1];
    assign mem.wr_addr_b = b_pipe[L-1];

    mod_butterfly i_bfly (
        .clk   (clk),
        .reset (reset),
        .in_a  (mem.rd_data_a),
        .in_b  (mem.rd_data_b),
        .tw    (tw),
        .out_a (mem.wr_data_a),
        .out_b (mem.wr_data_b)
    );

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            v_pipe <= '0;
        else
            v_pipe <= {v_pipe[L-2:0], state == COMPUTE};   // one issue per compute cycle
    end

    always_ff @(posedge clk) begin
        a_pipe[0] <= addr_a;
        b_pipe[0] <= addr_b;
        for (int i = 1; i < L; i++) begin
            a_pipe[i] <= a_pipe[i-1];
            b_pipe[i] <= b_pipe[i-1];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= IDLE;
            s          <= '0;
            j          <= '0;
            cnt        <= '0;
            done       <= 1'b0;
            dout       <= '0;
            dout_valid <= 1'b0;
        end else begin
            done       <= 1'b0;
            dout_valid <= (state == OUTPUT);   // registered read, one cycle behind
            case (state)
                IDLE: begin
                    s <= '0;
                    j <= '0;
                    if (start)
                        state <= COMPUTE;   // start while busy never reaches here
                end
                COMPUTE: begin
                    j <= j + 1'b1;
                    cnt <= '0;
                    if (j == 3'd7)
                        state <= DRAIN;
                end
                DRAIN: begin
                    // wait for in-flight butterflies before the next stage reads
                    cnt <= cnt + 1'b1;
                    if (cnt == ntt_pkg::addr_t'(L - 1)) begin
                        cnt <= '0;
                        if (s == 2'd3) begin
                            done  <= 1'b1;   // last write lands on this edge
                            state <= OUTPUT;
                        end else begin
                            s     <= s + 1'b1;
                            state <= COMPUTE;
                        end
                    end
                end
                default: begin   // OUTPUT
                    dout <= mem.rd_data_a;
                    cnt  <= cnt + 1'b1;
                    if (cnt == ntt_pkg::addr_t'(ntt_pkg::RING_SIZE - 1))
                        state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/ntt_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ntt top
// 16-point forward NTT mod 97: serial load, in-place
// transform, natural order serial readout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module ntt_top (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 load_data,   // 1 cc pulse, data follows next cycle
    input  wire                 start,       // 1 cc pulse, begins transform
    input  wire ntt_pkg::coef_t din,
    output logic                done,        // 1 cc pulse, output follows
    output ntt_pkg::coef_t      dout,
    output logic                dout_valid
);

    // loader to buffer
    logic           ld_en;
    ntt_pkg::addr_t ld_addr;
    ntt_pkg::coef_t ld_data;

    coef_mem_if mem_if ();   // butterfly side of the buffer

    ntt_loader i_loader (
        .clk       (clk),
        .reset     (reset),
        .load_data (load_data),
        .din       (din),
        .ld_en     (ld_en),
        .ld_addr   (ld_addr),
        .ld_data   (ld_data)
    );

    coef_buffer i_buffer (
        .clk     (clk),
        .reset   (reset),
        .ld_en   (ld_en),
        .ld_addr (ld_addr),
        .ld_data (ld_data),
        .mem     (mem_if)
    );

    ntt_ctrl i_ctrl (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .mem        (mem_if),
        .done       (done),
        .dout       (dout),
        .dout_valid (dout_valid)
    );

endmodule

`default_nettype wire

// ==== sim/ntt_checker.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ntt protocol checker
// done pulse, output window and range properties
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module ntt_checker (
    input wire                 clk,
    input wire                 reset,
    input wire                 done,
    input wire ntt_pkg::coef_t dout,
    input wire                 dout_valid
);

    logic [4:0] run_len;   // consecutive dout_valid cycles so far

    // failures per property
    int unsigned n_pulse = 0;
    int unsigned n_rise  = 0;
    int unsigned n_len   = 0;
    int unsigned n_range = 0;
    int unsigned n_reset = 0;
    int unsigned fail_count;

    assign fail_count = n_pulse + n_rise + n_len + n_range + n_reset;

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            run_len <= '0;
        else if (dout_valid)
            run_len <= run_len + 1'b1;
        else
            run_len <= '0;
    end

    a_done_pulse: assert property (@(posedge clk) disable iff (reset) done |=> !done)
    else begin
        $error("done high for two cycles in a row");
        n_pulse++;
    end

    // output window opens only right after done
    a_valid_rise: assert property (@(posedge clk) disable iff (reset)
        $rose(dout_valid) |-> $past(done))
    else begin
        $error("dout_valid rose without done in the cycle before");
        n_rise++;
    end

    a_valid_len: assert property (@(posedge clk) disable iff (reset)
        $fell(dout_valid) |-> run_len == 5'd16)
    else begin
        $error("dout_valid window was not 16 cycles");
        n_len++;
    end

    a_dout_range: assert property (@(posedge clk) disable iff (reset)
        dout_valid |-> dout < ntt_pkg::coef_t'(ntt_pkg::Q_MOD))
    else begin
        $error("dout not reduced mod q");
        n_range++;
    end

    a_reset_quiet: assert property (@(posedge clk) reset |-> !done && !dout_valid)
    else begin
        $error("done or dout_valid high during reset");
        n_reset++;
    end

endmodule

`default_nettype wire

// ==== sim/ntt_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ntt testbench
// impulse, random, repeat and start-while-busy runs checked
// against a direct DFT model mod 97
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module ntt_tb;

    localparam int N          = 16;
    localparam int Q          = 97;
    localparam int ROOT       = 8;      // 8^8 = -1 mod 97
    localparam int MAX_CYCLES = 2000;   // ~6 runs of 16 load + 44 compute + 16 out, margin
    localparam int FRAME_WAIT = 150;    // start to last output word is about 62 cycles

    logic           clk;
    logic           reset;
    logic           load_data;
    logic           start;
    ntt_pkg::coef_t din;
    logic           done;
    ntt_pkg::coef_t dout;
    logic           dout_valid;

    ntt_pkg::coef_t vec [N];        // input of the next transform
    ntt_pkg::coef_t expect_x [N];   // model result
    ntt_pkg::coef_t got [N];        // words captured after done

    int cycles      = 0;
    int frames      = 0;   // complete 16-word output frames
    int out_idx     = 0;
    int done_count  = 0;
    int valid_count = 0;
    int errors      = 0;
    int test_errors = 0;
    int tests_run   = 0;

    ntt_top i_ntt_top (
        .clk        (clk),
        .reset      (reset),
        .load_data  (load_data),
        .start      (start),
        .din        (din),
        .done       (done),
        .dout       (dout),
        .dout_valid (dout_valid)
    );

    bind ntt_top ntt_checker i_checker (
        .clk        (clk),
        .reset      (reset),
        .done       (done),
        .dout       (dout),
        .dout_valid (dout_valid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("timeout after %0d cycles, the tests did not finish", MAX_CYCLES);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // collector, sampled mid-cycle where outputs are settled
    always @(negedge clk) begin
        if (done) begin
            done_count <= done_count + 1;
            out_idx    <= 0;
        end
        if (dout_valid) begin
            got[out_idx] <= dout;
            valid_count  <= valid_count + 1;
            out_idx      <= (out_idx == N - 1) ? 0 : out_idx + 1;
            if (out_idx == N - 1)
                frames <= frames + 1;
        end
    end

    function automatic int pow_mod(input int base, input int e);
        int r;
        r = 1;
        for (int i = 0; i < e; i++)
            r = (r * base) % Q;
        return r;
    endfunction

    function automatic int bitrev(input int v);
        int r;
        r = 0;
        for (int i = 0; i < 4; i++)
            if (v[i])
                r = r | (1 << (3 - i));
        return r;
    endfunction

    // X[k] = sum x[j] * w^(jk) mod q
    task automatic dft_model;
        int acc;
        for (int k = 0; k < N; k++) begin
            acc = 0;
            for (int j = 0; j < N; j++)
                acc = (acc + int'(vec[j]) * pow_mod(ROOT, (j * k) % N)) % Q;
            expect_x[k] = ntt_pkg::coef_t'(acc);
        end
    endtask

    task automatic random_vector;
        for (int j = 0; j < N; j++)
            vec[j] = ntt_pkg::coef_t'($urandom % Q);
    endtask

    // load pulse, then one word per cycle in natural order
    task automatic load_vector;
        @(posedge clk);
        load_data <= 1'b1;
        @(posedge clk);
        load_data <= 1'b0;
        din       <= vec[0];
        for (int j = 1; j < N; j++) begin
            @(posedge clk);
            din <= vec[j];
        end
        repeat (3) @(posedge clk);   // last word lands in the buffer
        din <= '0;
    endtask

    task automatic pulse_start;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    // wait for the next full output frame and compare with the model
    task automatic wait_frame(input string name);
        int f0;
        int n;
        f0 = frames;
        n  = 0;
        while (frames == f0 && n < FRAME_WAIT) begin
            @(posedge clk);
            n++;
        end
        if (frames == f0) begin
            $display("%s: no output frame within %0d cycles of start", name, FRAME_WAIT);
            test_errors++;
        end else begin
            for (int k = 0; k < N; k++)
                if (got[k] !== expect_x[k]) begin
                    $display("FAIL %s X[%0d] expected %0d actual %0d",
                             name, k, expect_x[k], got[k]);
                    test_errors++;
                end
        end
    endtask

    task automatic end_test(input string name);
        if (test_errors == 0)
            $display("test %s ok", name);
        else
            $display("test %s had %0d errors", name, test_errors);
        errors      += test_errors;
        test_errors  = 0;
        tests_run++;
    endtask

    initial begin
        int d0;
        void'($urandom(32'hff1b));   // one seed for the whole run
        reset     = 1'b1;
        load_data = 1'b0;
        start     = 1'b0;
        din       = '0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        // nothing may come out before a start
        repeat (20) @(posedge clk);
        if (done_count != 0 || valid_count != 0) begin
            $display("reset: done or dout_valid went high without a start");
            test_errors++;
        end
        end_test("reset");

        for (int j = 0; j < N; j++) begin
            vec[j]      = '0;
            expect_x[j] = 7'd1;   // flat spectrum
        end
        vec[0] = 7'd1;
        load_vector();
        pulse_start();
        wait_frame("impulse");
        end_test("impulse");

        for (int t = 0; t < 4; t++) begin
            random_vector();
            dft_model();
            load_vector();
            pulse_start();
            wait_frame("random");
        end
        end_test("random");

        // buffer still holds X in natural order, read as bit-reversed input
        for (int j = 0; j < N; j++)
            vec[j] = expect_x[bitrev(j)];
        dft_model();
        pulse_start();
        wait_frame("repeat");
        end_test("repeat");

        random_vector();
        dft_model();
        load_vector();
        d0 = done_count;
        pulse_start();
        repeat (12) @(posedge clk);   // mid stage 1
        pulse_start();
        wait_frame("busy_start");
        repeat (60) @(posedge clk);   // room for a whole second transform
        if (done_count - d0 != 1) begin
            $display("FAIL busy_start done pulses expected 1 actual %0d", done_count - d0);
            test_errors++;
        end
        end_test("busy_start");

        if (i_ntt_top.i_checker.fail_count != 0) begin
            $display("protocol assertions failed %0d times", i_ntt_top.i_checker.fail_count);
            errors += int'(i_ntt_top.i_checker.fail_count);
        end
        $display("summary: %0d tests, %0d errors", tests_run, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== ntt_top.f ====
hdl/ntt_pkg.sv
hdl/coef_mem_if.sv
hdl/mod_butterfly.sv
hdl/ntt_loader.sv
hdl/coef_buffer.sv
hdl/ntt_ctrl.sv
hdl/ntt_top.sv
sim/ntt_checker.sv
sim/ntt_tb.sv

// ==== Makefile ====
# Verilator build and run for the NTT testbench

VERILATOR ?= verilator
TOP       ?= ntt_tb
FLIST     ?= ntt_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
RUNFLAGS  ?= +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUNFLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)
